// ==== hw/tx_pkg.sv ====
package tx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////
	localparam int LEN_W  = 11;
	localparam int SRC_AW = 16;

	// Frame type codes
	localparam logic [7:0] TYPE_ACK   = 8'h32;
	localparam logic [7:0] TYPE_LPASS = 8'h51;

	// Payload lengths in bytes
	localparam logic [LEN_W-1:0] ACK_PAYLOAD             = 11'd16;
	localparam logic [LEN_W-1:0] LPASS_PAYLOAD_SHORT_BUS = 11'd1024;
	localparam logic [LEN_W-1:0] LPASS_PAYLOAD_LONG_BUS  = 11'd64;

	// Header lengths, also the first payload address in the buffer
	localparam logic [LEN_W-1:0] ACK_HDR   = 11'd2;
	localparam logic [LEN_W-1:0] LPASS_HDR = 11'd4;

	////////////////////////////////////////////////////////////////////////////
	// Card identifier byte
	////////////////////////////////////////////////////////////////////////////
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] rsvd;
			logic       grp_hi;
			logic       grp_lo;
			logic [3:0] slot;
		} fields;
	} card_id_u;

endpackage

// ==== hw/byte_ram.sv ====
module byte_ram #(
	parameter int ADDR_W = 11
)(
	input  logic              sys_clk,
	input  logic              wren,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [7:0]        wdata,
	input  logic [ADDR_W-1:0] raddr,
	output logic [7:0]        rdata
);

	logic [7:0] mem [0:(1<<ADDR_W)-1];

	always_ff @(posedge sys_clk)
	begin
		if (wren)
			mem[waddr] <= wdata;
	end

	// Registered read, one cycle of latency
	always_ff @(posedge sys_clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

// ==== hw/tx_con.sv ====
module tx_con #(
	parameter bit LONG_BUS = 1'b0
)(
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  logic                      ack_tx_en,
	input  logic                      lpass_tx_en,
	input  logic [7:0]                id_now,
	input  tx_pkg::card_id_u          card_id,
	input  logic                      init_done,
	input  logic                      rd_wr_done,
	output logic                      rd_wr_start,
	output logic [tx_pkg::LEN_W-1:0]  rd_wr_len,
	output logic [tx_pkg::SRC_AW-1:0] rd_addr,
	output logic [tx_pkg::LEN_W-1:0]  wr_addr,
	output logic [tx_pkg::LEN_W-1:0]  tx_data_len,
	output logic                      tx_start,
	output logic                      hdr_wren,
	output logic [tx_pkg::LEN_W-1:0]  hdr_waddr,
	output logic [7:0]                hdr_wdata
);
	import tx_pkg::*;

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_HDR0 = 3'd1;
	localparam logic [2:0] ST_HDR1 = 3'd2;
	localparam logic [2:0] ST_HDR2 = 3'd3;
	localparam logic [2:0] ST_HDR3 = 3'd4;
	localparam logic [2:0] ST_END  = 3'd5;
	localparam logic [2:0] ST_WAIT = 3'd6;

	localparam logic [LEN_W-1:0] LPASS_PAYLOAD =
		LONG_BUS ? LPASS_PAYLOAD_LONG_BUS : LPASS_PAYLOAD_SHORT_BUS;
	localparam logic [LEN_W-1:0] LPASS_LEN = LPASS_HDR + LPASS_PAYLOAD;
	localparam logic [LEN_W-1:0] ACK_LEN   = ACK_HDR + ACK_PAYLOAD;

	logic [2:0]        state;
	logic [7:0]        min_id;
	logic [7:0]        max_id;
	logic [7:0]        win_lo;
	logic [7:0]        win_hi;
	logic [7:0]        single_id;
	card_id_u          card_q;
	logic [7:0]        id_off;
	logic              in_win;
	logic              accept;
	logic [SRC_AW-1:0] ack_src;
	logic [SRC_AW-1:0] lpass_src;
	logic [7:0]        frm_id;
	logic [7:0]        frm_type;
	logic [15:0]       sn;

	////////////////////////////////////////////////////////////////////////////
	// Id window
	////////////////////////////////////////////////////////////////////////////

	// Field-coded cards own exactly one node id
	assign single_id = (card_id.fields.grp_lo ? 8'd14 : 8'd0)
		+ (card_id.fields.grp_hi ? 8'd28 : 8'd0)
		+ 8'd30 - {4'd0, card_id.fields.slot};

	always_comb
	begin
		case (card_id.raw)
			8'd14:
			begin
				win_lo = 8'd0;
				win_hi = LONG_BUS ? 8'd11 : 8'd23;
			end
			8'd13:
			begin
				win_lo = LONG_BUS ? 8'd12 : 8'd24;
				win_hi = LONG_BUS ? 8'd23 : 8'd47;
			end
			8'd12:
			begin
				win_lo = 8'd48;
				win_hi = 8'd53;
			end
			8'd11:
			begin
				win_lo = 8'd54;
				win_hi = 8'd59;
			end
			8'd10:
			begin
				win_lo = 8'd60;
				win_hi = 8'd65;
			end
			8'd9:
			begin
				win_lo = 8'd66;
				win_hi = 8'd71;
			end
			default:
			begin
				win_lo = single_id;
				win_hi = single_id;
			end
		endcase
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			min_id <= 8'd0;
			max_id <= 8'd0;
			card_q <= '0;
		end
		else if (init_done)
		begin
			min_id <= win_lo;
			max_id <= win_hi;
			card_q <= card_id;
		end
	end

	assign in_win = (id_now >= min_id) && (id_now <= max_id);
	assign accept = (state == ST_IDLE) && in_win && (ack_tx_en || lpass_tx_en);
	assign id_off = id_now - min_id;

	////////////////////////////////////////////////////////////////////////////
	// Sample memory source address
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (card_q.raw)
			8'd13, 8'd14:
			begin
				ack_src = {4'd0, id_off, 4'd0};
				if (LONG_BUS)
					lpass_src = {2'd0, id_off, 6'd0}
						+ ((card_q.raw == 8'd14) ? 16'h0300 : 16'h00c0);
				else
					lpass_src = {id_off[5:0], 10'd0} + 16'h0180;
			end
			// One 1 KB page per node, one-hot
			8'd9, 8'd10, 8'd11, 8'd12:
			begin
				ack_src   = '0;
				lpass_src = 16'h0400 << id_off;
			end
			default:
			begin
				ack_src   = '0;
				lpass_src = 16'h8000;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state       <= ST_IDLE;
			rd_wr_start <= 1'b0;
			tx_start    <= 1'b0;
			hdr_wren    <= 1'b0;
			sn          <= 16'd0;
		end
		else
		begin
			rd_wr_start <= 1'b0;
			tx_start    <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (accept)
						state <= ST_HDR0;
					// Sequence bumps before use so the first frame carries 1
					if (accept && lpass_tx_en)
						sn <= sn + 16'd1;
				end
				ST_HDR0:
				begin
					hdr_wren <= 1'b1;
					state    <= ST_HDR1;
				end
				ST_HDR1:
					state <= ST_HDR2;
				ST_HDR2:
					state <= ST_HDR3;
				ST_HDR3:
					state <= ST_END;
				ST_END:
				begin
					hdr_wren    <= 1'b0;
					rd_wr_start <= 1'b1;
					state       <= ST_WAIT;
				end
				ST_WAIT:
				begin
					if (rd_wr_done)
					begin
						tx_start <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Frame setup and header bytes
	always_ff @(posedge sys_clk)
	begin
		if (accept)
		begin
			frm_id <= id_now;
			if (lpass_tx_en)
			begin
				frm_type    <= TYPE_LPASS;
				rd_wr_len   <= LPASS_PAYLOAD;
				wr_addr     <= LPASS_HDR;
				tx_data_len <= LPASS_LEN;
				rd_addr     <= lpass_src;
			end
			else
			begin
				frm_type    <= TYPE_ACK;
				rd_wr_len   <= ACK_PAYLOAD;
				wr_addr     <= ACK_HDR;
				tx_data_len <= ACK_LEN;
				rd_addr     <= ack_src;
			end
		end
		hdr_waddr <= {{(LEN_W-3){1'b0}}, state - ST_HDR0};
		case (state)
			ST_HDR0: hdr_wdata <= frm_id;
			ST_HDR1: hdr_wdata <= frm_type;
			ST_HDR2: hdr_wdata <= sn[15:8];
			default: hdr_wdata <= sn[7:0];
		endcase
	end

endmodule

// ==== hw/buf_copier.sv ====
module buf_copier (
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  logic                      rd_wr_start,
	input  logic [tx_pkg::LEN_W-1:0]  rd_wr_len,
	input  logic [tx_pkg::SRC_AW-1:0] rd_addr,
	input  logic [tx_pkg::LEN_W-1:0]  wr_addr,
	input  logic                      hdr_wren,
	input  logic [tx_pkg::LEN_W-1:0]  hdr_waddr,
	input  logic [7:0]                hdr_wdata,
	input  logic [7:0]                src_rdata,
	output logic                      rd_wr_done,
	output logic [tx_pkg::SRC_AW-1:0] src_raddr,
	output logic                      buf_wren,
	output logic [tx_pkg::LEN_W-1:0]  buf_waddr,
	output logic [7:0]                buf_wdata
);
	import tx_pkg::*;

	logic             rd_act;
	logic             wr_act;
	logic             busy;
	logic [LEN_W-1:0] rd_cnt;
	logic [LEN_W-1:0] wr_ptr;

	// Read side, one address per cycle
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			rd_act     <= 1'b0;
			wr_act     <= 1'b0;
			rd_wr_done <= 1'b0;
		end
		else
		begin
			wr_act     <= rd_act;
			rd_wr_done <= wr_act && !rd_act;
			if (rd_wr_start)
				rd_act <= 1'b1;
			else if (rd_act && rd_cnt == '0)
				rd_act <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (rd_wr_start)
		begin
			src_raddr <= rd_addr;
			rd_cnt    <= rd_wr_len - 1'b1;
			wr_ptr    <= wr_addr;
		end
		else
		begin
			if (rd_act && rd_cnt != '0)
			begin
				src_raddr <= src_raddr + 1'b1;
				rd_cnt    <= rd_cnt - 1'b1;
			end
			// Write stage trails the read by one cycle
			if (wr_act)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	assign busy = rd_act | wr_act;

	// Header bytes pass through only between copies
	assign buf_wren  = busy ? wr_act : hdr_wren;
	assign buf_waddr = busy ? wr_ptr : hdr_waddr;
	assign buf_wdata = busy ? src_rdata : hdr_wdata;

endmodule

// ==== hw/frame_sender.sv ====
module frame_sender (
	input  logic                     sys_clk,
	input  logic                     glbl_rst_n,
	input  logic                     tx_start,
	input  logic [tx_pkg::LEN_W-1:0] tx_data_len,
	input  logic [7:0]               buf_rdata,
	output logic [tx_pkg::LEN_W-1:0] buf_raddr,
	output logic                     tx_valid,
	output logic [7:0]               tx_byte,
	output logic                     tx_last
);
	import tx_pkg::*;

	logic             rd_act;
	logic [LEN_W-1:0] rd_cnt;

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			rd_act   <= 1'b0;
			tx_valid <= 1'b0;
			tx_last  <= 1'b0;
		end
		else
		begin
			// Flags lag the address by the RAM read cycle
			tx_valid <= rd_act;
			tx_last  <= rd_act && rd_cnt == '0;
			if (tx_start)
				rd_act <= 1'b1;
			else if (rd_act && rd_cnt == '0)
				rd_act <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (tx_start)
		begin
			buf_raddr <= '0;
			rd_cnt    <= tx_data_len - 1'b1;
		end
		else if (rd_act && rd_cnt != '0)
		begin
			buf_raddr <= buf_raddr + 1'b1;
			rd_cnt    <= rd_cnt - 1'b1;
		end
	end

	assign tx_byte = buf_rdata;

endmodule

// ==== hw/tx_top.sv ====
module tx_top #(
	parameter bit LONG_BUS = 1'b0
)(
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  logic                      ack_tx_en,
	input  logic                      lpass_tx_en,
	input  logic [7:0]                id_now,
	input  tx_pkg::card_id_u          card_id,
	input  logic                      init_done,
	input  logic                      src_wren,
	input  logic [tx_pkg::SRC_AW-1:0] src_waddr,
	input  logic [7:0]                src_wdata,
	output logic                      tx_valid,
	output logic [7:0]                tx_byte,
	output logic                      tx_last
);
	import tx_pkg::*;

	// Copy request
	logic              rd_wr_start;
	logic              rd_wr_done;
	logic [LEN_W-1:0]  rd_wr_len;
	logic [SRC_AW-1:0] rd_addr;
	logic [LEN_W-1:0]  wr_addr;

	// Header writes
	logic              hdr_wren;
	logic [LEN_W-1:0]  hdr_waddr;
	logic [7:0]        hdr_wdata;

	// Sample memory read
	logic [SRC_AW-1:0] src_raddr;
	logic [7:0]        src_rdata;

	// Transmit buffer ports
	logic              buf_wren;
	logic [LEN_W-1:0]  buf_waddr;
	logic [7:0]        buf_wdata;
	logic [LEN_W-1:0]  buf_raddr;
	logic [7:0]        buf_rdata;

	logic              tx_start;
	logic [LEN_W-1:0]  tx_data_len;

	tx_con #(
		.LONG_BUS (LONG_BUS)
	) u_tx_con (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.ack_tx_en   (ack_tx_en),
		.lpass_tx_en (lpass_tx_en),
		.id_now      (id_now),
		.card_id     (card_id),
		.init_done   (init_done),
		.rd_wr_done  (rd_wr_done),
		.rd_wr_start (rd_wr_start),
		.rd_wr_len   (rd_wr_len),
		.rd_addr     (rd_addr),
		.wr_addr     (wr_addr),
		.tx_data_len (tx_data_len),
		.tx_start    (tx_start),
		.hdr_wren    (hdr_wren),
		.hdr_waddr   (hdr_waddr),
		.hdr_wdata   (hdr_wdata)
	);

	buf_copier u_buf_copier (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.rd_wr_start (rd_wr_start),
		.rd_wr_len   (rd_wr_len),
		.rd_addr     (rd_addr),
		.wr_addr     (wr_addr),
		.hdr_wren    (hdr_wren),
		.hdr_waddr   (hdr_waddr),
		.hdr_wdata   (hdr_wdata),
		.src_rdata   (src_rdata),
		.rd_wr_done  (rd_wr_done),
		.src_raddr   (src_raddr),
		.buf_wren    (buf_wren),
		.buf_waddr   (buf_waddr),
		.buf_wdata   (buf_wdata)
	);

	frame_sender u_frame_sender (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.tx_start    (tx_start),
		.tx_data_len (tx_data_len),
		.buf_rdata   (buf_rdata),
		.buf_raddr   (buf_raddr),
		.tx_valid    (tx_valid),
		.tx_byte     (tx_byte),
		.tx_last     (tx_last)
	);

	// 64 KB sample memory, loaded by the host
	byte_ram #(
		.ADDR_W (SRC_AW)
	) u_src_mem (
		.sys_clk (sys_clk),
		.wren    (src_wren),
		.waddr   (src_waddr),
		.wdata   (src_wdata),
		.raddr   (src_raddr),
		.rdata   (src_rdata)
	);

	// 2 KB transmit buffer
	byte_ram #(
		.ADDR_W (LEN_W)
	) u_tx_buf (
		.sys_clk (sys_clk),
		.wren    (buf_wren),
		.waddr   (buf_waddr),
		.wdata   (buf_wdata),
		.raddr   (buf_raddr),
		.rdata   (buf_rdata)
	);

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen #(
	parameter int PERIOD = 100
)(
	output logic sys_clk
);

	initial
	begin
		sys_clk = 1'b0;
		forever
			#(PERIOD / 2) sys_clk = ~sys_clk;
	end

endmodule

// ==== verif/tx_chk.sv ====
module tx_chk (
	input logic                     sys_clk,
	input logic                     glbl_rst_n,
	input logic                     rd_wr_start,
	input logic                     rd_wr_done,
	input logic [tx_pkg::LEN_W-1:0] rd_wr_len,
	input logic                     trig,
	input logic                     idle
);
	import tx_pkg::*;

	logic             cpy_busy;
	logic [LEN_W+1:0] cpy_cyc;
	logic [LEN_W+1:0] done_at;

	// Edges seen since the copy request
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			cpy_busy <= 1'b0;
			cpy_cyc  <= '0;
		end
		else if (rd_wr_start)
		begin
			cpy_busy <= 1'b1;
			cpy_cyc  <= (LEN_W+2)'(1);
		end
		else if (cpy_busy)
		begin
			cpy_cyc <= cpy_cyc + (LEN_W+2)'(1);
			if (rd_wr_done)
				cpy_busy <= 1'b0;
		end
	end

	assign done_at = {2'b00, rd_wr_len} + (LEN_W+2)'(2);

	a_start_pulse: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		rd_wr_start |=> !rd_wr_start)
		else $error("rd_wr_start is longer than one cycle");

	a_done_time: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		rd_wr_done |-> (cpy_busy && cpy_cyc == done_at))
		else $error("rd_wr_done not at rd_wr_len + 2 cycles after start");

	a_done_late: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		cpy_busy |-> (cpy_cyc <= done_at))
		else $error("rd_wr_done overdue");

	a_trig_idle: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		trig |-> idle)
		else $error("Trigger seen outside idle");

endmodule

////////////////////////////////////////////////////////////////////////////
// Attachments
////////////////////////////////////////////////////////////////////////////
bind tx_con tx_chk u_con_chk (
	.sys_clk     (sys_clk),
	.glbl_rst_n  (glbl_rst_n),
	.rd_wr_start (rd_wr_start),
	.rd_wr_done  (rd_wr_done),
	.rd_wr_len   (rd_wr_len),
	.trig        (ack_tx_en || lpass_tx_en),
	.idle        (state == ST_IDLE)
);

// Copy request must find the copier idle
bind buf_copier tx_chk u_cpy_chk (
	.sys_clk     (sys_clk),
	.glbl_rst_n  (glbl_rst_n),
	.rd_wr_start (rd_wr_start),
	.rd_wr_done  (rd_wr_done),
	.rd_wr_len   (rd_wr_len),
	.trig        (rd_wr_start),
	.idle        (!busy)
);

// ==== verif/tb_top.sv ====
module tb_top;
	import tx_pkg::*;

	localparam int RST_CYC   = 10;
	localparam int FILL_CYC  = 1 << SRC_AW;
	localparam int ACK_PAY   = 16;
	localparam int LPASS_PAY = 1024;
	// Trigger to first byte is payload + 10, then the frame itself
	localparam int ACK_CYC   = 2 + (ACK_PAY + 10) + (ACK_PAY + 2) + 2;
	localparam int LPASS_CYC = 2 + (LPASS_PAY + 10) + (LPASS_PAY + 4) + 2;
	localparam int IGN_WAIT  = LPASS_PAY + 10 + 6;
	localparam int N_ACK     = 9;
	localparam int N_LPASS   = 14;
	localparam int N_IGN     = 4;
	localparam int N_INIT    = 8;
	localparam int RUN_CYC   = RST_CYC + FILL_CYC + N_ACK * ACK_CYC + N_LPASS * LPASS_CYC
		+ N_IGN * (IGN_WAIT + 2) + N_INIT * 4 + 2000;

	logic              sys_clk;
	logic              glbl_rst_n;
	logic              ack_tx_en;
	logic              lpass_tx_en;
	logic [7:0]        id_now;
	card_id_u          card_id;
	logic              init_done;
	logic              src_wren;
	logic [SRC_AW-1:0] src_waddr;
	logic [7:0]        src_wdata;
	logic              tx_valid;
	logic [7:0]        tx_byte;
	logic              tx_last;

	// Model state
	logic [7:0]  src_model [0:(1<<SRC_AW)-1];
	logic [7:0]  exp_q [$];
	logic [15:0] sn_model;
	card_id_u    card_model;
	logic [7:0]  model_lo;
	logic [7:0]  model_hi;
	bit          expect_frame;
	int          rx_cnt;
	int          frames_done;
	integer      seed;

	tb_clk_gen #(
		.PERIOD (100)
	) u_clk_gen (
		.sys_clk (sys_clk)
	);

	tx_top #(
		.LONG_BUS (1'b0)
	) u_dut (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.ack_tx_en   (ack_tx_en),
		.lpass_tx_en (lpass_tx_en),
		.id_now      (id_now),
		.card_id     (card_id),
		.init_done   (init_done),
		.src_wren    (src_wren),
		.src_waddr   (src_waddr),
		.src_wdata   (src_wdata),
		.tx_valid    (tx_valid),
		.tx_byte     (tx_byte),
		.tx_last     (tx_last)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic void ref_window(input card_id_u c, output logic [7:0] lo,
		output logic [7:0] hi);
		int v;
		v = 30 - int'(c.fields.slot);
		if (c.fields.grp_lo)
			v = v + 14;
		if (c.fields.grp_hi)
			v = v + 28;
		lo = 8'(v);
		hi = 8'(v);
		case (c.raw)
			8'd14:
			begin
				lo = 8'd0;
				hi = 8'd23;
			end
			8'd13:
			begin
				lo = 8'd24;
				hi = 8'd47;
			end
			8'd12:
			begin
				lo = 8'd48;
				hi = 8'd53;
			end
			8'd11:
			begin
				lo = 8'd54;
				hi = 8'd59;
			end
			8'd10:
			begin
				lo = 8'd60;
				hi = 8'd65;
			end
			8'd9:
			begin
				lo = 8'd66;
				hi = 8'd71;
			end
			default:
				;
		endcase
	endfunction

	function automatic logic [15:0] ref_src(input card_id_u c, input logic [7:0] id,
		input bit lpass, input logic [7:0] lo);
		int idv;
		int a;
		idv = int'(id);
		if (!lpass)
			a = (c.raw == 8'd14) ? 16 * idv : (c.raw == 8'd13) ? 16 * (idv - 24) : 0;
		else if (c.raw == 8'd14)
			a = (idv % 64) * 1024 + 'h180;
		else if (c.raw == 8'd13)
			a = ((idv - 24) % 64) * 1024 + 'h180;
		else if (c.raw >= 8'd9 && c.raw <= 8'd12)
			a = 1024 << (idv - int'(lo));
		else
			a = 'h8000;
		// Wraps at 64 KB
		return 16'(a);
	endfunction

	function automatic void build_frame(input card_id_u c, input logic [7:0] id,
		input bit lpass, input logic [15:0] sn);
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [15:0] src;
		int          pay;
		int          k;
		ref_window(c, lo, hi);
		src = ref_src(c, id, lpass, lo);
		exp_q.delete();
		exp_q.push_back(id);
		if (lpass)
		begin
			exp_q.push_back(TYPE_LPASS);
			exp_q.push_back(sn[15:8]);
			exp_q.push_back(sn[7:0]);
			pay = int'(LPASS_PAYLOAD_SHORT_BUS);
		end
		else
		begin
			exp_q.push_back(TYPE_ACK);
			pay = int'(ACK_PAYLOAD);
		end
		for (k = 0; k < pay; k++)
			exp_q.push_back(src_model[16'(int'(src) + k)]);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////
	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input string name, input logic [LEN_W-1:0] got,
		input logic [LEN_W-1:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Registered outputs, sampled at the rising edge
	always @(posedge sys_clk)
	begin
		if (glbl_rst_n && tx_valid)
		begin
			if (!expect_frame)
			begin
				$display("Output byte at %0t while no frame was expected", $time);
				abort_run();
			end
			else if (rx_cnt >= exp_q.size())
			begin
				$display("Frame at %0t is longer than %0d bytes", $time, exp_q.size());
				abort_run();
			end
			else
			begin
				check_byte($sformatf("tx_byte[%0d]", rx_cnt), tx_byte, exp_q[rx_cnt]);
				rx_cnt++;
				if (tx_last)
				begin
					check_len("frame length", LEN_W'(rx_cnt), LEN_W'(exp_q.size()));
					rx_cnt = 0;
					frames_done++;
				end
			end
		end
	end

	initial
	begin
		repeat (RUN_CYC) @(posedge sys_clk);
		$display("Timeout: the run did not end within %0d clock cycles", RUN_CYC);
		abort_run();
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	task automatic load_samples();
		int         a;
		logic [7:0] val;
		for (a = 0; a < FILL_CYC; a++)
		begin
			@(negedge sys_clk);
			val = 8'(a ^ (a >> 8)) + 8'($random(seed));
			src_model[a] = val;
			src_wren = 1'b1;
			src_waddr = SRC_AW'(a);
			src_wdata = val;
		end
		@(negedge sys_clk);
		src_wren = 1'b0;
	endtask

	task automatic load_card(input logic [7:0] raw);
		@(negedge sys_clk);
		card_id.raw = raw;
		init_done = 1'b1;
		@(negedge sys_clk);
		init_done = 1'b0;
		card_model.raw = raw;
		ref_window(card_model, model_lo, model_hi);
	endtask

	// Long-pass wins when both triggers are set
	task automatic issue_trigger(input logic [7:0] id, input bit ack, input bit lpass);
		bit accepted;
		int target;
		@(negedge sys_clk);
		accepted = (id >= model_lo) && (id <= model_hi);
		if (accepted && lpass)
			sn_model = sn_model + 16'd1;
		if (accepted)
			build_frame(card_model, id, lpass, sn_model);
		target = frames_done + 1;
		expect_frame = accepted;
		id_now = id;
		ack_tx_en = ack;
		lpass_tx_en = lpass;
		@(negedge sys_clk);
		ack_tx_en = 1'b0;
		lpass_tx_en = 1'b0;
		if (accepted)
			wait (frames_done == target);
		else
			repeat (IGN_WAIT) @(negedge sys_clk);
		expect_frame = 1'b0;
	endtask

	initial
	begin
		int c;
		seed = 92567;
		glbl_rst_n = 1'b0;
		ack_tx_en = 1'b0;
		lpass_tx_en = 1'b0;
		id_now = 8'd0;
		card_id.raw = 8'd0;
		init_done = 1'b0;
		src_wren = 1'b0;
		src_waddr = '0;
		src_wdata = 8'd0;
		sn_model = 16'd0;
		card_model.raw = 8'd0;
		model_lo = 8'd0;
		model_hi = 8'd0;
		expect_frame = 1'b0;
		rx_cnt = 0;
		frames_done = 0;
		repeat (RST_CYC) @(negedge sys_clk);
		glbl_rst_n = 1'b1;

		load_samples();

		// Window is 0..0 until the first init_done
		issue_trigger(8'd5, 1'b0, 1'b1);

		load_card(8'd14);
		issue_trigger(8'd0, 1'b1, 1'b0);
		issue_trigger(8'd5, 1'b1, 1'b0);
		issue_trigger(8'd23, 1'b1, 1'b0);
		// Rejected id, then a frame that shows the sequence held
		issue_trigger(8'd24, 1'b0, 1'b1);
		issue_trigger(8'd7, 1'b0, 1'b1);

		load_card(8'd13);
		issue_trigger(8'd24, 1'b0, 1'b1);
		issue_trigger(8'd30, 1'b0, 1'b1);

		// One-hot pages, both window edges
		for (c = 9; c <= 12; c++)
		begin
			load_card(8'(c));
			issue_trigger(model_lo, 1'b0, 1'b1);
			issue_trigger(model_hi, 1'b0, 1'b1);
			issue_trigger(model_lo, 1'b1, 1'b0);
		end

		// Field-coded cards, single id each
		load_card(8'h23);
		issue_trigger(model_lo, 1'b0, 1'b1);
		issue_trigger(model_lo, 1'b1, 1'b0);
		issue_trigger(model_lo + 8'd1, 1'b0, 1'b1);
		load_card(8'h17);
		issue_trigger(model_lo, 1'b0, 1'b1);
		issue_trigger(model_lo, 1'b1, 1'b0);
		issue_trigger(model_lo + 8'd1, 1'b1, 1'b0);

		issue_trigger(model_lo, 1'b1, 1'b1);

		repeat (4) @(negedge sys_clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== compile.f ====
hw/tx_pkg.sv
hw/byte_ram.sv
hw/tx_con.sv
hw/buf_copier.sv
hw/frame_sender.sv
hw/tx_top.sv
verif/tb_clk_gen.sv
verif/tx_chk.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
